// File: common/dcachePkg.sv
`default_nettype none

package dcachePkg;

  ////////////////////////////////////////
  // Cache geometry
  ////////////////////////////////////////

  localparam int AddrBits    = 32;
  localparam int DataBits    = 32;
  // Byte within a word, word within a line
  localparam int ByteOffBits = 2;
  localparam int WordOffBits = 2;
  localparam int IndexBits   = 4;
  localparam int TagBits     = AddrBits - IndexBits - WordOffBits - ByteOffBits;
  localparam int LineBytes   = 2 ** (WordOffBits + ByteOffBits);
  localparam int LineBits    = LineBytes * 8;
  localparam int NumLines    = 2 ** IndexBits;

  // Store buffer depth, kept a power of two so pointers wrap on their own
  localparam int StbDepth    = 4;
  localparam int StbPtrBits  = $clog2(StbDepth);

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  // Ordered by size so that sizes compare directly
  typedef enum logic [1:0] {
    SizeByte = 2'd0,
    SizeHalf = 2'd1,
    SizeWord = 2'd2
  } accessSize_t;

  // One address, seen raw or split into cache fields
  typedef union packed {
    logic [AddrBits-1:0] raw;
    struct packed {
      logic [TagBits-1:0]     tag;
      logic [IndexBits-1:0]   index;
      logic [WordOffBits-1:0] wordOff;
      logic [ByteOffBits-1:0] byteOff;
    } f;
  } addrWord_u;

  // Buffered store, data already moved to its byte lane
  typedef struct packed {
    addrWord_u           addr;
    logic [DataBits-1:0] data;
    logic [3:0]          byteEn;
    accessSize_t         size;
  } stbEntry_t;

  // Write-through request to memory
  typedef struct packed {
    logic [AddrBits-1:0] addr;
    logic [DataBits-1:0] data;
    logic [3:0]          byteEn;
  } memStReq_t;

  // Line request, addressed by line only
  typedef struct packed {
    logic [TagBits-1:0]   tag;
    logic [IndexBits-1:0] index;
  } memLdReq_t;

  // Line returned by memory
  typedef struct packed {
    logic [TagBits-1:0]   tag;
    logic [IndexBits-1:0] index;
    logic [LineBits-1:0]  data;
  } memFill_t;

  // Registered fill going into the arrays
  typedef struct packed {
    logic [TagBits-1:0]   tag;
    logic [IndexBits-1:0] index;
    logic [LineBits-1:0]  data;
  } lineWrite_t;

endpackage

`default_nettype wire

// File: hw/accessAlign.sv
`default_nettype none

module accessAlign (
  // Store side
  input  wire dcachePkg::addrWord_u   stAddr_i,
  input  wire dcachePkg::accessSize_t stSize_i,
  input  wire logic [31:0]            stData_i,
  output      logic [31:0]            stWord_o,
  output      logic [3:0]             stByteEn_o,
  // Load side
  input  wire dcachePkg::addrWord_u   ldAddr_i,
  input  wire dcachePkg::accessSize_t ldSize_i,
  input  wire logic [31:0]            rawWord_i,
  output      logic [31:0]            ldData_o
);

  // Store alignment
  // Low byte or half moves up to the lane the address selects
  always_comb
  begin
    case (stSize_i)
      dcachePkg::SizeByte:
      begin
        stWord_o   = (stData_i & 32'h0000_00ff) << {stAddr_i.f.byteOff, 3'b000};
        stByteEn_o = 4'b0001 << stAddr_i.f.byteOff;
      end
      dcachePkg::SizeHalf:
      begin
        // Half-words only sit in lane 0 or lane 2
        stWord_o   = (stData_i & 32'h0000_ffff) << {stAddr_i.f.byteOff[1], 4'b0000};
        stByteEn_o = 4'b0011 << {stAddr_i.f.byteOff[1], 1'b0};
      end
      default:
      begin
        stWord_o   = stData_i;
        stByteEn_o = 4'b1111;
      end
    endcase
  end

  // Load extraction
  // Addressed lane comes down to bit 0, upper bits zero-filled
  always_comb
  begin
    case (ldSize_i)
      dcachePkg::SizeByte:
        ldData_o = (rawWord_i >> {ldAddr_i.f.byteOff, 3'b000}) & 32'h0000_00ff;
      dcachePkg::SizeHalf:
        ldData_o = (rawWord_i >> {ldAddr_i.f.byteOff[1], 4'b0000}) & 32'h0000_ffff;
      default:
        ldData_o = rawWord_i;
    endcase
  end

endmodule

`default_nettype wire

// File: storeBuffer/storeBuffer.sv
`default_nettype none

module storeBuffer (
  input  wire logic                   clk,
  input  wire logic                   reset,

  // New store, already aligned
  input  wire logic                   stEn_i,
  input  wire dcachePkg::addrWord_u   stAddr_i,
  input  wire dcachePkg::accessSize_t stSize_i,
  input  wire logic [31:0]            stWord_i,
  input  wire logic [3:0]             stByteEn_i,

  // Memory side
  input  wire logic                   stComplete_i,
  input  wire logic                   memStStall_i,
  output      dcachePkg::memStReq_t   memStReq_o,
  output      logic                   memStValid_o,
  output      logic                   stallStCommit_o,

  // Load forwarding
  input  wire dcachePkg::addrWord_u   ldAddr_i,
  output      logic                   fwdHit_o,
  output      logic [31:0]            fwdWord_o,
  output      dcachePkg::accessSize_t fwdSize_o,

  // Oldest store, handed to the arrays on retirement
  output      dcachePkg::stbEntry_t   head_o,
  output      logic                   headRetire_o
);

  dcachePkg::stbEntry_t                entries [dcachePkg::StbDepth];
  logic [dcachePkg::StbDepth-1:0]      entryValid;
  logic [dcachePkg::StbPtrBits-1:0]    head;
  logic [dcachePkg::StbPtrBits-1:0]    tail;
  logic                                full;
  logic                                accept;
  logic [dcachePkg::StbPtrBits-1:0]    youngest;

  // Pointers meet with the slot still taken
  assign full            = (tail == head) & entryValid[head];
  assign accept          = stEn_i & ~full;
  assign stallStCommit_o = full | memStStall_i;

  assign head_o       = entries[head];
  assign headRetire_o = stComplete_i & entryValid[head];

  ////////////////////////////////////////
  // Enqueue and retire
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      head       <= '0;
      tail       <= '0;
      entryValid <= '0;
    end
    else
    begin
      if (accept)
      begin
        entryValid[tail] <= 1'b1;
        tail             <= tail + 1'b1;
      end
      // Completions come back in order, so the head is always the one done
      if (headRetire_o)
      begin
        entryValid[head] <= 1'b0;
        head             <= head + 1'b1;
      end
    end
  end

  // Entry payload
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      entries[tail].addr   <= stAddr_i;
      entries[tail].data   <= stWord_i;
      entries[tail].byteEn <= stByteEn_i;
      entries[tail].size   <= stSize_i;
    end
  end

  ////////////////////////////////////////
  // Write-through request
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      memStValid_o <= 1'b0;
    end
    else
    begin
      memStValid_o <= accept;
    end
  end

  // Request payload follows the accepted store
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      memStReq_o.addr   <= stAddr_i.raw;
      memStReq_o.data   <= stWord_i;
      memStReq_o.byteEn <= stByteEn_i;
    end
  end

  ////////////////////////////////////////
  // Forwarding search
  ////////////////////////////////////////

  // Walk from head toward tail, last match seen is the youngest
  always_comb
  begin
    logic [dcachePkg::StbPtrBits-1:0] idx;
    idx      = head;
    fwdHit_o = 1'b0;
    youngest = head;
    for (int i = 0; i < dcachePkg::StbDepth; i++)
    begin
      if (entryValid[idx] && (entries[idx].addr.raw == ldAddr_i.raw))
      begin
        fwdHit_o = 1'b1;
        youngest = idx;
      end
      idx = idx + 1'b1;
    end
  end

  assign fwdWord_o = entries[youngest].data;
  assign fwdSize_o = entries[youngest].size;

endmodule

`default_nettype wire

// File: hw/missHandler.sv
`default_nettype none

module missHandler (
  input  wire logic                 clk,
  input  wire logic                 reset,

  // Load lookup
  input  wire logic                 ldEn_i,
  input  wire dcachePkg::addrWord_u ldAddr_i,
  input  wire logic                 ldHit_i,

  // Memory side
  input  wire dcachePkg::memFill_t  memFill_i,
  input  wire logic                 memFillValid_i,
  output      dcachePkg::memLdReq_t memLdReq_o,
  output      logic                 memLdValid_o,

  // Registered fill to the arrays
  output      dcachePkg::lineWrite_t fill_o,
  output      logic                  fillValid_o
);

  dcachePkg::addrWord_u             ldAddrD1;
  logic                             missD1;
  logic                             missD2;
  logic                             missPulse;
  logic                             sameLine;

  // Single miss-status register
  logic                             mshrValid;
  logic [dcachePkg::TagBits-1:0]    mshrTag;
  logic [dcachePkg::IndexBits-1:0]  mshrIndex;

  ////////////////////////////////////////
  // Miss detection
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      missD1 <= 1'b0;
      missD2 <= 1'b0;
    end
    else
    begin
      missD1 <= ldEn_i & ~ldHit_i;
      // A fill drops the history, so a load still missing asks again
      missD2 <= missD1 & ~fillValid_o;
    end
  end

  // Address lines up with missD1
  always_ff @(posedge clk)
  begin
    ldAddrD1 <= ldAddr_i;
  end

  // Rising edge of a run of missing cycles
  assign missPulse = missD1 & ~missD2;
  assign sameLine  = (fill_o.tag == ldAddrD1.f.tag) & (fill_o.index == ldAddrD1.f.index);

  assign memLdReq_o.tag   = ldAddrD1.f.tag;
  assign memLdReq_o.index = ldAddrD1.f.index;

  // Request if the register is free or a fill for another line frees it now
  assign memLdValid_o = missPulse & (~mshrValid | (fillValid_o & ~sameLine));

  ////////////////////////////////////////
  // Miss register
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      mshrValid <= 1'b0;
    end
    else if (memLdValid_o)
    begin
      mshrValid <= 1'b1;
    end
    else if (fillValid_o)
    begin
      mshrValid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (memLdValid_o)
    begin
      mshrTag   <= ldAddrD1.f.tag;
      mshrIndex <= ldAddrD1.f.index;
    end
  end

  ////////////////////////////////////////
  // Fill staging
  ////////////////////////////////////////

  // Stray fills for another line are dropped here
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      fillValid_o <= 1'b0;
    end
    else
    begin
      fillValid_o <= memFillValid_i & mshrValid & (memFill_i.tag == mshrTag) &
                     (memFill_i.index == mshrIndex);
    end
  end

  always_ff @(posedge clk)
  begin
    fill_o.tag   <= memFill_i.tag;
    fill_o.index <= memFill_i.index;
    fill_o.data  <= memFill_i.data;
  end

endmodule

`default_nettype wire

// File: hw/cacheArrays.sv
`default_nettype none

module cacheArrays (
  input  wire logic                   clk,
  input  wire logic                   reset,

  // Load lookup
  input  wire logic                   ldEn_i,
  input  wire dcachePkg::addrWord_u   ldAddr_i,
  input  wire dcachePkg::accessSize_t ldSize_i,
  input  wire logic                   fwdHit_i,
  input  wire logic [31:0]            fwdWord_i,
  input  wire dcachePkg::accessSize_t fwdSize_i,

  // Store retirement
  input  wire dcachePkg::stbEntry_t   head_i,
  input  wire logic                   headRetire_i,

  // Line fill
  input  wire dcachePkg::lineWrite_t  fill_i,
  input  wire logic                   fillValid_i,

  output      logic [31:0]            ldWord_o,
  output      logic                   ldHit_o,
  output      logic                   stHit_o,
  output      logic                   stMiss_o
);

  logic [dcachePkg::LineBits-1:0] dataArray [dcachePkg::NumLines];
  logic [dcachePkg::TagBits-1:0]  tagArray  [dcachePkg::NumLines];
  logic [dcachePkg::NumLines-1:0] validArray;

  logic [dcachePkg::LineBits-1:0] ldLine;
  logic                           ldResident;
  logic [dcachePkg::IndexBits-1:0] stIndex;
  logic                           stResident;
  logic [dcachePkg::LineBits-1:0] mergeLine;
  logic                           fillSameLine;

  ////////////////////////////////////////
  // Load lookup
  ////////////////////////////////////////

  assign ldLine     = dataArray[ldAddr_i.f.index];
  assign ldResident = validArray[ldAddr_i.f.index] &
                      (tagArray[ldAddr_i.f.index] == ldAddr_i.f.tag);

  // Buffered store is newer than the line, so it wins outright
  assign ldWord_o = fwdHit_i ? fwdWord_i
                  : ldLine[ldAddr_i.f.wordOff*dcachePkg::DataBits +: dcachePkg::DataBits];

  // Wider load than the buffered store would mix old bytes, so it misses
  assign ldHit_o = fwdHit_i ? (ldEn_i & (ldSize_i <= fwdSize_i)) : (ldEn_i & ldResident);

  ////////////////////////////////////////
  // Store update
  ////////////////////////////////////////

  assign stIndex    = head_i.addr.f.index;
  assign stResident = validArray[stIndex] & (tagArray[stIndex] == head_i.addr.f.tag);
  assign stHit_o    = headRetire_i & stResident;
  // No allocate on a store miss
  assign stMiss_o   = headRetire_i & ~stResident;

  // Enabled bytes of the head overlay the resident line
  always_comb
  begin
    mergeLine = dataArray[stIndex];
    for (int j = 0; j < dcachePkg::DataBits / 8; j++)
    begin
      if (head_i.byteEn[j])
      begin
        mergeLine[(head_i.addr.f.wordOff*4 + j)*8 +: 8] = head_i.data[j*8 +: 8];
      end
    end
  end

  // Line being replaced needs no store update
  assign fillSameLine = fillValid_i & (fill_i.index == stIndex);

  always_ff @(posedge clk)
  begin
    if (fillValid_i)
    begin
      dataArray[fill_i.index] <= fill_i.data;
      tagArray[fill_i.index]  <= fill_i.tag;
    end
    if (stHit_o && !fillSameLine)
    begin
      dataArray[stIndex] <= mergeLine;
    end
  end

  // Valid bits, set by fills only
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      validArray <= '0;
    end
    else if (fillValid_i)
    begin
      validArray[fill_i.index] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hw/dcacheTop.sv
`default_nettype none

module dcacheTop (
  input  wire logic                   clk,
  input  wire logic                   reset,

  // Load port
  input  wire logic                   ldEn_i,
  input  wire dcachePkg::addrWord_u   ldAddr_i,
  input  wire dcachePkg::accessSize_t ldSize_i,
  output      logic [31:0]            ldData_o,
  output      logic                   ldHit_o,
  output      logic                   ldMiss_o,

  // Store port
  input  wire logic                   stEn_i,
  input  wire dcachePkg::addrWord_u   stAddr_i,
  input  wire dcachePkg::accessSize_t stSize_i,
  input  wire logic [31:0]            stData_i,
  output      logic                   stallStCommit_o,
  output      logic                   stHit_o,
  output      logic                   stMiss_o,

  // Memory side
  output      dcachePkg::memLdReq_t   dc2memLdReq_o,
  output      logic                   dc2memLdValid_o,
  input  wire dcachePkg::memFill_t    mem2dcFill_i,
  input  wire logic                   mem2dcFillValid_i,
  output      dcachePkg::memStReq_t   dc2memStReq_o,
  output      logic                   dc2memStValid_o,
  input  wire logic                   mem2dcStComplete_i,
  input  wire logic                   mem2dcStStall_i
);

  // Aligned store word and lanes
  logic [dcachePkg::DataBits-1:0] stWord;
  logic [3:0]                     stByteEn;
  // Word picked by the arrays before load extraction
  logic [dcachePkg::DataBits-1:0] rawLdWord;
  logic                           ldHit;

  // Forwarding from the store buffer
  logic                           fwdHit;
  logic [dcachePkg::DataBits-1:0] fwdWord;
  dcachePkg::accessSize_t         fwdSize;

  // Head of the store buffer and its retirement
  dcachePkg::stbEntry_t           stbHead;
  logic                           headRetire;
  logic                           stCompleteD1;

  // Fill into the arrays
  dcachePkg::lineWrite_t          fill;
  logic                           fillValid;

  assign ldHit_o  = ldHit;
  assign ldMiss_o = ldEn_i & ~ldHit;

  // Completion is staged once before it retires the head
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      stCompleteD1 <= 1'b0;
    end
    else
    begin
      stCompleteD1 <= mem2dcStComplete_i;
    end
  end

  accessAlign accessAlign_i (
    .stAddr_i   (stAddr_i),
    .stSize_i   (stSize_i),
    .stData_i   (stData_i),
    .stWord_o   (stWord),
    .stByteEn_o (stByteEn),
    .ldAddr_i   (ldAddr_i),
    .ldSize_i   (ldSize_i),
    .rawWord_i  (rawLdWord),
    .ldData_o   (ldData_o)
  );

  storeBuffer storeBuffer_i (
    .clk             (clk),
    .reset           (reset),
    .stEn_i          (stEn_i),
    .stAddr_i        (stAddr_i),
    .stSize_i        (stSize_i),
    .stWord_i        (stWord),
    .stByteEn_i      (stByteEn),
    .stComplete_i    (stCompleteD1),
    .memStStall_i    (mem2dcStStall_i),
    .ldAddr_i        (ldAddr_i),
    .memStReq_o      (dc2memStReq_o),
    .memStValid_o    (dc2memStValid_o),
    .stallStCommit_o (stallStCommit_o),
    .fwdHit_o        (fwdHit),
    .fwdWord_o       (fwdWord),
    .fwdSize_o       (fwdSize),
    .head_o          (stbHead),
    .headRetire_o    (headRetire)
  );

  missHandler missHandler_i (
    .clk            (clk),
    .reset          (reset),
    .ldEn_i         (ldEn_i),
    .ldAddr_i       (ldAddr_i),
    .ldHit_i        (ldHit),
    .memFill_i      (mem2dcFill_i),
    .memFillValid_i (mem2dcFillValid_i),
    .memLdReq_o     (dc2memLdReq_o),
    .memLdValid_o   (dc2memLdValid_o),
    .fill_o         (fill),
    .fillValid_o    (fillValid)
  );

  cacheArrays cacheArrays_i (
    .clk          (clk),
    .reset        (reset),
    .ldEn_i       (ldEn_i),
    .ldAddr_i     (ldAddr_i),
    .ldSize_i     (ldSize_i),
    .fwdHit_i     (fwdHit),
    .fwdWord_i    (fwdWord),
    .fwdSize_i    (fwdSize),
    .head_i       (stbHead),
    .headRetire_i (headRetire),
    .fill_i       (fill),
    .fillValid_i  (fillValid),
    .ldWord_o     (rawLdWord),
    .ldHit_o      (ldHit),
    .stHit_o      (stHit_o),
    .stMiss_o     (stMiss_o)
  );

endmodule

`default_nettype wire

// File: test/tbClock.sv
`default_nettype none

module tbClock (
  output logic clk_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // 40 ns period, starts low so the first edge is a rising one at 20 ns
  initial
  begin
    clk_o = 1'b0;
    forever
    begin
      #20 clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// File: test/dcacheTb.sv
`default_nettype none

module dcacheTb;

  timeunit 1ns;
  timeprecision 1ps;

  // Run length per phase
  localparam int LoadCycles  = 40;
  localparam int MixedCycles = 500;
  localparam int FullCycles  = 30;
  localparam int TailCycles  = 200;
  localparam int TotalCycles = 4 + LoadCycles + MixedCycles + FullCycles + TailCycles;
  localparam int TimeoutCycles = 4 * TotalCycles;

  localparam int ModeIdle  = 0;
  localparam int ModeLoads = 1;
  localparam int ModeMixed = 2;
  localparam int ModeFull  = 3;

  logic clk;
  logic reset;
  logic ldEn;
  dcachePkg::addrWord_u ldAddr;
  dcachePkg::accessSize_t ldSize;
  logic [31:0] ldData;
  logic ldHit;
  logic ldMiss;
  logic stEn;
  dcachePkg::addrWord_u stAddr;
  dcachePkg::accessSize_t stSize;
  logic [31:0] stData;
  logic stallStCommit;
  logic stHit;
  logic stMiss;
  dcachePkg::memLdReq_t ldReq;
  logic ldReqValid;
  dcachePkg::memFill_t fill;
  logic fillValid;
  dcachePkg::memStReq_t stReq;
  logic stReqValid;
  logic stComplete;
  logic stStall;

  ////////////////////////////////////////
  // Reference and memory model state
  ////////////////////////////////////////

  int seed;
  int cycleCount;
  logic [31:0] memWords [logic [29:0]];
  logic [dcachePkg::TagBits-1:0] refTag [dcachePkg::NumLines];
  logic refValid [dcachePkg::NumLines];
  logic [dcachePkg::LineBits-1:0] refLine [dcachePkg::NumLines];
  // Front is the oldest buffered store
  dcachePkg::stbEntry_t pendQ [$];
  dcachePkg::memStReq_t memQ [$];

  logic fillPending;
  int fillDelay;
  dcachePkg::memLdReq_t fillReq;
  logic fillStageValid;
  dcachePkg::memFill_t fillStage;
  logic mshrBusy;
  logic missD1;
  logic missD2;
  dcachePkg::addrWord_u addrD1;
  int stDelay;
  logic holdComp;
  logic compD1;
  logic stAccD1;
  dcachePkg::memStReq_t expStReq;
  logic expHit;
  logic expReq;
  logic sawFull;

  tbClock tbClock_i (.clk_o(clk));

  dcacheTop dcacheTop_i (
    .clk                (clk),
    .reset              (reset),
    .ldEn_i             (ldEn),
    .ldAddr_i           (ldAddr),
    .ldSize_i           (ldSize),
    .ldData_o           (ldData),
    .ldHit_o            (ldHit),
    .ldMiss_o           (ldMiss),
    .stEn_i             (stEn),
    .stAddr_i           (stAddr),
    .stSize_i           (stSize),
    .stData_i           (stData),
    .stallStCommit_o    (stallStCommit),
    .stHit_o            (stHit),
    .stMiss_o           (stMiss),
    .dc2memLdReq_o      (ldReq),
    .dc2memLdValid_o    (ldReqValid),
    .mem2dcFill_i       (fill),
    .mem2dcFillValid_i  (fillValid),
    .dc2memStReq_o      (stReq),
    .dc2memStValid_o    (stReqValid),
    .mem2dcStComplete_i (stComplete),
    .mem2dcStStall_i    (stStall)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic failRun(input string reason);
    $display("Test failed");
    $display("%s at %0t", reason, $time);
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [127:0] actual,
                            input logic [127:0] expected);
    if (actual !== expected)
    begin
      $display("Test failed");
      $display("[ERROR] t=%0t %s: got %0h, expected %0h", $time, name, actual, expected);
      $fatal(1);
    end
  endtask

  function automatic int randBelow(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r[30:0]) % n;
  endfunction

  // Three lines where two of them fight over index 2
  function automatic logic [27:0] lineAddr(input int sel);
    case (sel)
      0: return {24'h000a12, 4'd2};
      1: return {24'h000a12, 4'd3};
      default: return {24'h000b34, 4'd2};
    endcase
  endfunction

  function automatic int sizeBytes(input dcachePkg::accessSize_t size);
    case (size)
      dcachePkg::SizeByte: return 1;
      dcachePkg::SizeHalf: return 2;
      default: return 4;
    endcase
  endfunction

  function automatic dcachePkg::addrWord_u randomAddr(input dcachePkg::accessSize_t size);
    dcachePkg::addrWord_u a;
    logic [1:0] wo;
    logic [1:0] bo;
    wo = 2'(randBelow(4));
    bo = 2'(randBelow(4));
    // Aligned to the access size
    if (size == dcachePkg::SizeHalf)
    begin
      bo = {bo[1], 1'b0};
    end
    else if (size == dcachePkg::SizeWord)
    begin
      bo = 2'b00;
    end
    a.raw = {lineAddr(randBelow(3)), wo, bo};
    return a;
  endfunction

  // Memory content before any store mixes every address bit
  function automatic logic [31:0] readWord(input logic [29:0] wa);
    logic [31:0] a;
    if (memWords.exists(wa))
    begin
      return memWords[wa];
    end
    a = {wa, 2'b00};
    return a ^ {a[15:0], a[31:16]} ^ 32'hc3a5_5a3c;
  endfunction

  // Byte k of the data lands in lane offset+k
  function automatic logic [31:0] alignWord(input dcachePkg::addrWord_u a,
                                            input dcachePkg::accessSize_t size,
                                            input logic [31:0] data);
    logic [31:0] w;
    int off;
    w = '0;
    off = int'(a.f.byteOff);
    for (int k = 0; k < sizeBytes(size); k++)
    begin
      w[(off + k)*8 +: 8] = data[k*8 +: 8];
    end
    return w;
  endfunction

  function automatic logic [3:0] alignEn(input dcachePkg::addrWord_u a,
                                         input dcachePkg::accessSize_t size);
    logic [3:0] en;
    int off;
    en = '0;
    off = int'(a.f.byteOff);
    for (int k = 0; k < sizeBytes(size); k++)
    begin
      en[off + k] = 1'b1;
    end
    return en;
  endfunction

  // Lanes come down to byte 0 and the rest stays zero
  function automatic logic [31:0] extractLoad(input logic [31:0] word,
                                              input dcachePkg::addrWord_u a,
                                              input dcachePkg::accessSize_t size);
    logic [31:0] r;
    int off;
    r = '0;
    off = int'(a.f.byteOff);
    for (int k = 0; k < sizeBytes(size); k++)
    begin
      r[k*8 +: 8] = word[(off + k)*8 +: 8];
    end
    return r;
  endfunction

  function automatic logic resident(input dcachePkg::addrWord_u a);
    return refValid[a.f.index] && (refTag[a.f.index] == a.f.tag);
  endfunction

  ////////////////////////////////////////
  // Drive, check and advance one cycle
  ////////////////////////////////////////

  task automatic driveCycle(input int mode);
    logic blockComp;
    ldEn       = 1'b0;
    stEn       = 1'b0;
    stStall    = 1'b0;
    stComplete = 1'b0;
    fillValid  = 1'b0;
    holdComp   = (mode == ModeFull);
    ldSize     = dcachePkg::accessSize_t'(2'(randBelow(3)));
    ldAddr     = randomAddr(ldSize);
    stSize     = dcachePkg::accessSize_t'(2'(randBelow(3)));
    stAddr     = randomAddr(stSize);
    stData     = $random(seed);
    if (mode != ModeIdle)
    begin
      ldEn = (randBelow(2) == 1);
    end
    if (mode == ModeMixed)
    begin
      stStall = (randBelow(8) == 0);
      // Commit logic backs off while stalled
      stEn = !stStall && (pendQ.size() < dcachePkg::StbDepth) && (randBelow(3) == 0);
    end
    else if (mode == ModeFull)
    begin
      // Stores keep coming even when full so back-pressure gets exercised
      stEn = 1'b1;
    end
    // No store completes while a fill is on its way
    blockComp = fillPending;
    if (fillPending && (fillDelay == 0))
    begin
      fill.tag   = fillReq.tag;
      fill.index = fillReq.index;
      for (int w = 0; w < 4; w++)
      begin
        fill.data[w*32 +: 32] = readWord({fillReq.tag, fillReq.index, 2'(w)});
      end
      fillValid   = 1'b1;
      fillPending = 1'b0;
    end
    if (!holdComp && !blockComp && (memQ.size() > 0) && (stDelay == 0))
    begin
      logic [31:0] w;
      w = readWord(memQ[0].addr[31:2]);
      for (int b = 0; b < 4; b++)
      begin
        if (memQ[0].byteEn[b])
        begin
          w[b*8 +: 8] = memQ[0].data[b*8 +: 8];
        end
      end
      memWords[memQ[0].addr[31:2]] = w;
      void'(memQ.pop_front());
      stComplete = 1'b1;
      stDelay    = randBelow(4);
    end
  endtask

  task automatic checkCycle();
    logic found;
    logic sameLine;
    logic [31:0] expData;
    dcachePkg::stbEntry_t fwd;
    dcachePkg::memLdReq_t expLdReq;
    found   = 1'b0;
    expHit  = 1'b0;
    expData = '0;
    fwd     = '0;
    if (ldEn)
    begin
      // Last match in the queue is the youngest store
      foreach (pendQ[i])
      begin
        if (pendQ[i].addr.raw == ldAddr.raw)
        begin
          found = 1'b1;
          fwd   = pendQ[i];
        end
      end
      if (found)
      begin
        expHit  = (ldSize <= fwd.size);
        expData = extractLoad(fwd.data, ldAddr, ldSize);
      end
      else if (resident(ldAddr))
      begin
        expHit  = 1'b1;
        expData = extractLoad(refLine[ldAddr.f.index][int'(ldAddr.f.wordOff)*32 +: 32],
                              ldAddr, ldSize);
      end
    end
    checkValue("ldHit_o", 128'(ldHit), 128'(expHit));
    checkValue("ldMiss_o", 128'(ldMiss), 128'(ldEn & ~expHit));
    if (expHit)
    begin
      checkValue("ldData_o", 128'(ldData), 128'(expData));
    end
    checkValue("stallStCommit_o", 128'(stallStCommit),
               128'((pendQ.size() == dcachePkg::StbDepth) | stStall));
    // Stall seen on the DUT output itself
    if (stallStCommit)
    begin
      sawFull = 1'b1;
    end
    // Write-through request follows the accepted store by one cycle
    checkValue("dc2memStValid_o", 128'(stReqValid), 128'(stAccD1));
    if (stReqValid)
    begin
      checkValue("dc2memStReq_o", 128'(stReq), 128'(expStReq));
      memQ.push_back(stReq);
    end
    checkValue("stHit_o", 128'(stHit), 128'(compD1 && resident(pendQ[0].addr)));
    checkValue("stMiss_o", 128'(stMiss), 128'(compD1 && !resident(pendQ[0].addr)));
    // Line request on the first cycle of a run of misses
    sameLine = (fillStage.tag == addrD1.f.tag) && (fillStage.index == addrD1.f.index);
    expReq   = missD1 & ~missD2 & (~mshrBusy | (fillStageValid & ~sameLine));
    checkValue("dc2memLdValid_o", 128'(ldReqValid), 128'(expReq));
    if (ldReqValid)
    begin
      expLdReq.tag   = addrD1.f.tag;
      expLdReq.index = addrD1.f.index;
      checkValue("dc2memLdReq_o", 128'(ldReq), 128'(expLdReq));
      fillPending = 1'b1;
      fillReq     = ldReq;
      fillDelay   = 2 + randBelow(5);
    end
  endtask

  task automatic updateModel();
    logic full;
    dcachePkg::stbEntry_t e;
    full = (pendQ.size() == dcachePkg::StbDepth);
    if (compD1)
    begin
      e = pendQ.pop_front();
      if (resident(e.addr))
      begin
        for (int b = 0; b < 4; b++)
        begin
          if (e.byteEn[b])
          begin
            refLine[e.addr.f.index][(int'(e.addr.f.wordOff)*4 + b)*8 +: 8] = e.data[b*8 +: 8];
          end
        end
      end
    end
    if (fillStageValid)
    begin
      refLine[fillStage.index]  = fillStage.data;
      refTag[fillStage.index]   = fillStage.tag;
      refValid[fillStage.index] = 1'b1;
    end
    if (expReq)
    begin
      mshrBusy = 1'b1;
    end
    else if (fillStageValid)
    begin
      mshrBusy = 1'b0;
    end
    missD2 = missD1 & ~fillStageValid;
    missD1 = ldEn & ~expHit;
    addrD1 = ldAddr;
    fillStageValid = fillValid;
    fillStage      = fill;
    stAccD1 = stEn & ~full;
    if (stAccD1)
    begin
      e.addr   = stAddr;
      e.data   = alignWord(stAddr, stSize, stData);
      e.byteEn = alignEn(stAddr, stSize);
      e.size   = stSize;
      pendQ.push_back(e);
      expStReq.addr   = stAddr.raw;
      expStReq.data   = e.data;
      expStReq.byteEn = e.byteEn;
    end
    compD1 = stComplete;
    if (fillPending && (fillDelay > 0))
    begin
      fillDelay--;
    end
    if (stDelay > 0)
    begin
      stDelay--;
    end
  endtask

  task automatic runCycle(input int mode);
    driveCycle(mode);
    // Sample a quarter period after the drive and well before the rising edge
    #10;
    checkCycle();
    updateModel();
    @(negedge clk);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial
  begin
    seed       = 32'hb718_3235;
    reset      = 1'b1;
    ldEn       = 1'b0;
    ldAddr     = '0;
    ldSize     = dcachePkg::SizeByte;
    stEn       = 1'b0;
    stAddr     = '0;
    stSize     = dcachePkg::SizeByte;
    stData     = '0;
    fill       = '0;
    fillValid  = 1'b0;
    stComplete = 1'b0;
    stStall    = 1'b0;
    for (int i = 0; i < dcachePkg::NumLines; i++)
    begin
      refValid[i] = 1'b0;
      refTag[i]   = '0;
      refLine[i]  = '0;
    end
    fillPending    = 1'b0;
    fillDelay      = 0;
    fillReq        = '0;
    fillStageValid = 1'b0;
    fillStage      = '0;
    mshrBusy       = 1'b0;
    missD1         = 1'b0;
    missD2         = 1'b0;
    addrD1         = '0;
    stDelay        = 0;
    holdComp       = 1'b0;
    compD1         = 1'b0;
    stAccD1        = 1'b0;
    expStReq       = '0;
    sawFull        = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    repeat (LoadCycles) runCycle(ModeLoads);
    repeat (MixedCycles) runCycle(ModeMixed);
    sawFull = 1'b0;
    repeat (FullCycles) runCycle(ModeFull);
    if (!sawFull)
    begin
      failRun("Store commit stall never rose with completions held back");
    end
    repeat (TailCycles) runCycle(ModeMixed);
    // Let memory finish everything still in flight
    while ((pendQ.size() > 0) || (memQ.size() > 0) || fillPending || fillStageValid)
    begin
      runCycle(ModeIdle);
    end
    $display("Test passed");
    $finish;
  end

  // Watchdog
  initial
  begin
    cycleCount = 0;
    forever
    begin
      @(posedge clk);
      cycleCount++;
      if (cycleCount >= TimeoutCycles)
      begin
        failRun("Run did not finish within the cycle limit");
      end
    end
  end

endmodule

`default_nettype wire

// File: sources.f
common/dcachePkg.sv
hw/accessAlign.sv
storeBuffer/storeBuffer.sv
hw/missHandler.sv
hw/cacheArrays.sv
hw/dcacheTop.sv
test/tbClock.sv
test/dcacheTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dcacheTb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

FILELIST := sources.f
SOURCES  := $(shell cat $(FILELIST))
SIM      := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
